// File: tb/icache_vectors.txt
# op addr_or_index expected_word miss way name
# miss 0 hit, 1 one refill, 2 either; way 9 any, for I the way to clear; H needs addr hits
R 00001004 5a5a4a5e 1 0 cold_miss
R 00001004 5a5a4a5e 0 9 repeat_hit
R 00001008 5a5a4a52 0 9 same_line_hit
R 00010020 5a5b5a7a 1 0 alloc_way0
R 00020024 5a585a7e 1 1 alloc_way1
R 00030028 5a595a72 1 2 alloc_way2
R 0004002c 5a5e5a76 1 3 alloc_way3
R 00010020 5a5b5a7a 0 9 full_hit0
R 00020024 5a585a7e 0 9 full_hit1
R 00030028 5a595a72 0 9 full_hit2
R 0004002c 5a5e5a76 0 9 full_hit3
R 00050020 5a5f5a7a 1 9 evict_miss
R 00050020 5a5f5a7a 2 9 after_evict0
R 00010020 5a5b5a7a 2 9 after_evict1
R 00020024 5a585a7e 2 9 after_evict2
R 00030028 5a595a72 2 9 after_evict3
R 0004002c 5a5e5a76 2 9 after_evict4
H 00000003 00000000 0 9 hits_after_evict
R 80000108 da5a5b52 1 9 nc_miss
R 80000108 da5a5b52 1 9 nc_repeat
I 00000000 00000000 0 0 inv_set0_way0
R 00001004 5a5a4a5e 1 0 inv_way_miss
A 00000002 00000000 0 9 inv_all_set2
R 00010020 5a5b5a7a 1 0 inv_all_miss0
R 00020024 5a585a7e 1 1 inv_all_miss1
R 00030028 5a595a72 1 2 inv_all_miss2
R 0004002c 5a5e5a76 1 3 inv_all_miss3
F 00000000 00000000 0 9 flush_walk
R 00001004 5a5a4a5e 1 0 flush_miss0
R 00050020 5a5f5a7a 1 0 flush_miss1

// File: project.f
rtl/icache_pkg.sv
rtl/icache_sram.sv
rtl/icache_way_select.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_sram.sv
  - rtl/icache_way_select.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_top.sv
  - target: test
    files:
      - tb/icache_tb.sv

// File: tb/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int unsigned NUM_WAYS = 4;
  // wait limit in cycles
  localparam int          TIMEOUT  = 200;
  localparam logic [31:0] MEM_XOR  = 32'h5a5a5a5a;
  // way column value for a refill way that is not checked
  localparam int          ANY_WAY  = 9;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        req_valid;
  logic        req_ready;
  fetch_req_t  req;
  logic        rsp_valid;
  logic        rsp_ready;
  fetch_rsp_t  rsp;
  logic        refill_valid;
  logic        refill_ready;
  refill_req_t refill;
  logic        rtrn_valid;
  mem_rtrn_t   rtrn;
  logic        miss;
  logic        busy;

  int unsigned lcg_state = 90;
  int          err_cnt;
  int          test_cnt;
  int          test_errs;
  // hits among reads whose outcome is not fixed
  int          hit_tally;
  logic        abort;

  icache_top #(
    .NUM_WAYS (NUM_WAYS)
  ) dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_i        (flush),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp),
    .rsp_ready_i    (rsp_ready),
    .refill_valid_o (refill_valid),
    .refill_o       (refill),
    .refill_ready_i (refill_ready),
    .rtrn_valid_i   (rtrn_valid),
    .rtrn_i         (rtrn),
    .miss_o         (miss),
    .busy_o         (busy)
  );

  // 4 ns period
  always #2 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  // memory word is its own address xor a fixed pattern
  function automatic line_t mem_line(input logic [31:0] line_addr);
    line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = (line_addr + 32'(4 * w)) ^ MEM_XOR;
    end
    return line;
  endfunction

  // lands on the drive point, 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic value_error(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s: %s expected %h actual %h", name, what, exp, act);
    test_errs++;
  endtask

  task automatic plain_error(input string name, input string msg);
    $display("ERROR %s: %s", name, msg);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    err_cnt += test_errs;
    if (test_errs == 0) begin
      $display("ok   %s", name);
    end else begin
      $display("bad  %s (%0d errors)", name, test_errs);
    end
  endtask

  ////////////////////
  // operations
  ////////////////////

  // busy for one cycle per set, nothing else may move
  task automatic check_flush_walk(input string name);
    int cycles;
    cycles = 0;
    #1;
    while (busy && cycles < TIMEOUT) begin
      if (req_ready || rsp_valid || refill_valid || miss) begin
        plain_error(name, "handshake or miss active during the flush walk");
      end
      cycles++;
      next_cycle();
      #1;
    end
    if (busy) begin
      plain_error(name, "timed out waiting for the flush walk to end");
      abort = 1'b1;
    end else begin
      if (cycles != NUM_SETS) begin
        value_error(name, "flush cycles", NUM_SETS, 32'(cycles));
      end
      if (!req_ready) begin
        plain_error(name, "request not ready after the flush walk");
      end
    end
    next_cycle();
  endtask

  task automatic do_flush(input string name);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    check_flush_walk(name);
  endtask

  task automatic do_invalidate(input logic [INDEX_WIDTH-1:0] idx, input int way,
                               input logic all_ways);
    rtrn_valid   = 1'b1;
    rtrn.rtype   = RTRN_INV;
    rtrn.inv_idx = idx;
    rtrn.inv_way = WAY_WIDTH'(way);
    rtrn.inv_all = all_ways;
    next_cycle();
    rtrn_valid   = 1'b0;
  endtask

  // hold valid until ready, returns before the accepting edge
  task automatic send_request(input logic [31:0] addr, input string name,
                              output logic accepted);
    int cycles;
    cycles    = 0;
    req_valid = 1'b1;
    req.paddr = addr;
    #1;
    while (!req_ready && cycles < TIMEOUT) begin
      cycles++;
      next_cycle();
      #1;
    end
    accepted = req_ready;
    if (!accepted) begin
      plain_error(name, "timed out waiting for req_ready");
      abort = 1'b1;
    end
  endtask

  // serves refills from the memory model until the response shows up
  task automatic await_response(input logic [31:0] addr, input logic [31:0] exp_word,
                                input int exp_flag, input int exp_way, input string name);
    logic [31:0] line_addr;
    int          edges;
    int          refills;
    int          delay;
    logic        miss_seen;
    logic        exp_miss;
    line_addr = {addr[31:4], 4'h0};
    refills   = 0;
    delay     = 0;
    miss_seen = 1'b0;
    next_cycle();
    req_valid = 1'b0;
    edges     = 1;
    #1;
    while (!rsp_valid && edges < TIMEOUT) begin
      if (refill_valid && refill_ready) begin
        refills++;
        miss_seen = miss_seen | miss;
        if (refill.paddr !== line_addr) begin
          value_error(name, "refill paddr", line_addr, refill.paddr);
        end
        if (refill.nc !== addr[NC_BIT]) begin
          value_error(name, "refill nc", 32'(addr[NC_BIT]), 32'(refill.nc));
        end
        if (exp_way != ANY_WAY && refill.way !== WAY_WIDTH'(exp_way)) begin
          value_error(name, "refill way", 32'(exp_way), 32'(refill.way));
        end
        // line comes back 1 to 6 cycles later
        delay = 1 + int'(lcg_next() % 6);
      end else if (miss) begin
        plain_error(name, "miss_o pulsed without a refill handshake");
      end
      next_cycle();
      edges++;
      rtrn_valid = 1'b0;
      if (delay > 0) begin
        delay--;
        if (delay == 0) begin
          rtrn_valid = 1'b1;
          rtrn.rtype = RTRN_ACK;
          rtrn.data  = mem_line(line_addr);
        end
      end
      #1;
    end
    if (!rsp_valid) begin
      plain_error(name, "timed out waiting for rsp_valid");
      abort = 1'b1;
    end else begin
      exp_miss = (refills > 0) && !addr[NC_BIT];
      if (rsp.data !== exp_word) begin
        value_error(name, "word", exp_word, rsp.data);
      end
      if (rsp.paddr !== addr) begin
        value_error(name, "rsp paddr", addr, rsp.paddr);
      end
      if (exp_flag == 0 && refills != 0) begin
        value_error(name, "refills", 0, 32'(refills));
      end
      // acceptance edge plus the compare edge
      if (exp_flag == 0 && edges != 2) begin
        value_error(name, "hit latency", 2, 32'(edges));
      end
      if (exp_flag == 1 && refills != 1) begin
        value_error(name, "refills", 1, 32'(refills));
      end
      if (miss_seen !== exp_miss) begin
        value_error(name, "miss_o", 32'(exp_miss), 32'(miss_seen));
      end
      if (exp_flag == 2 && refills == 0) begin
        hit_tally++;
      end
    end
  endtask

  // random back-pressure, response must hold and no request may enter
  task automatic take_response(input string name);
    fetch_rsp_t held;
    int         stall;
    held  = rsp;
    stall = int'(lcg_next() % 4);
    for (int i = 0; i < stall; i++) begin
      next_cycle();
      #1;
      if (!rsp_valid || rsp !== held) begin
        plain_error(name, "response changed under back-pressure");
      end
      if (req_ready) begin
        plain_error(name, "request ready while a response is pending");
      end
    end
    next_cycle();
    rsp_ready = 1'b1;
    next_cycle();
    rsp_ready = 1'b0;
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [31:0] exp_word,
                         input int exp_flag, input int exp_way, input string name);
    logic accepted;
    send_request(addr, name, accepted);
    if (accepted) begin
      await_response(addr, exp_word, exp_flag, exp_way, name);
      if (!abort) begin
        take_response(name);
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int          fd;
    int          code;
    string       text;
    string       name;
    byte         op;
    logic [31:0] arg;
    logic [31:0] word;
    int          flag;
    int          way;
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b0;
    // memory takes every refill at once
    refill_ready = 1'b1;
    rtrn_valid   = 1'b0;
    rtrn         = '0;
    err_cnt      = 0;
    test_cnt     = 0;
    hit_tally    = 0;
    abort        = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    test_errs = 0;
    check_flush_walk("reset_walk");
    finish_test("reset_walk");
    fd = $fopen("tb/icache_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR cannot open tb/icache_vectors.txt");
      err_cnt++;
    end else begin
      while (!abort && $fgets(text, fd)) begin
        // comment and blank lines do not scan fully
        code = $sscanf(text, "%c %h %h %d %d %s", op, arg, word, flag, way, name);
        if (code == 6) begin
          test_errs = 0;
          case (op)
            "R": do_read(arg, word, flag, way, name);
            "I": do_invalidate(arg[INDEX_WIDTH-1:0], way, 1'b0);
            "A": do_invalidate(arg[INDEX_WIDTH-1:0], 0, 1'b1);
            "F": do_flush(name);
            "H": begin
              if (hit_tally < int'(arg)) begin
                value_error(name, "minimum hits", arg, 32'(hit_tally));
              end
              hit_tally = 0;
            end
            default: plain_error(name, "unknown operation in the vector file");
          endcase
          finish_test(name);
        end
      end
      $fclose(fd);
    end
    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NUM_WAYS = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // fetch request
  input  logic                    req_valid_i,
  input  icache_pkg::fetch_req_t  req_i,
  output logic                    req_ready_o,
  // fetch response
  output logic                    rsp_valid_o,
  output icache_pkg::fetch_rsp_t  rsp_o,
  input  logic                    rsp_ready_i,
  // refill request
  output logic                    refill_valid_o,
  output icache_pkg::refill_req_t refill_o,
  input  logic                    refill_ready_i,
  // memory return, always consumed
  input  logic                    rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t   rtrn_i,
  // status
  output logic                    miss_o,
  output logic                    busy_o
);
  import icache_pkg::*;

  logic                      hit;
  logic [FETCH_WIDTH-1:0]    hit_word;
  logic [WAY_WIDTH-1:0]      repl_way;
  logic [TAG_WIDTH-1:0]      tag;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic                      alloc;

  // array control from the controller
  logic [NUM_WAYS-1:0]       tag_req, tag_we;
  logic [INDEX_WIDTH-1:0]    tag_addr;
  tag_entry_t                tag_wdata;
  logic [NUM_WAYS-1:0]       data_req, data_we;
  logic [INDEX_WIDTH-1:0]    data_addr;

  // per-way read data
  tag_entry_t [NUM_WAYS-1:0] tag_rdata;
  line_t [NUM_WAYS-1:0]      line_rdata;

  icache_ctrl #(
    .NUM_WAYS (NUM_WAYS)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o),
    .rsp_ready_i    (rsp_ready_i),
    .refill_valid_o (refill_valid_o),
    .refill_o       (refill_o),
    .refill_ready_i (refill_ready_i),
    .rtrn_valid_i   (rtrn_valid_i),
    .rtrn_i         (rtrn_i),
    .hit_i          (hit),
    .hit_word_i     (hit_word),
    .repl_way_i     (repl_way),
    .tag_o          (tag),
    .word_sel_o     (word_sel),
    .alloc_o        (alloc),
    .tag_req_o      (tag_req),
    .tag_we_o       (tag_we),
    .tag_addr_o     (tag_addr),
    .tag_wdata_o    (tag_wdata),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .miss_o         (miss_o),
    .busy_o         (busy_o)
  );

  icache_way_select #(
    .NUM_WAYS (NUM_WAYS)
  ) u_way_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tag_rdata_i  (tag_rdata),
    .line_rdata_i (line_rdata),
    .tag_i        (tag),
    .word_sel_i   (word_sel),
    .alloc_i      (alloc),
    .hit_o        (hit),
    .hit_word_o   (hit_word),
    .repl_way_o   (repl_way)
  );

  ////////////////////
  // per-way arrays
  ////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // valid bit and tag
    icache_sram #(
      .NUM_ENTRIES (NUM_SETS),
      .entry_t     (tag_entry_t)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[w]),
      .we_i    (tag_we[w]),
      .addr_i  (tag_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    // fill line comes straight from the return port
    icache_sram #(
      .NUM_ENTRIES (NUM_SETS),
      .entry_t     (line_t)
    ) u_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (data_req[w]),
      .we_i    (data_we[w]),
      .addr_i  (data_addr),
      .wdata_i (rtrn_i.data),
      .rdata_o (line_rdata[w])
    );
  end

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned NUM_WAYS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  req_valid_i,
  input  icache_pkg::fetch_req_t                req_i,
  output logic                                  req_ready_o,
  output logic                                  rsp_valid_o,
  output icache_pkg::fetch_rsp_t                rsp_o,
  input  logic                                  rsp_ready_i,
  output logic                                  refill_valid_o,
  output icache_pkg::refill_req_t               refill_o,
  input  logic                                  refill_ready_i,
  input  logic                                  rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t                 rtrn_i,
  input  logic                                  hit_i,
  input  logic [icache_pkg::FETCH_WIDTH-1:0]    hit_word_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]      repl_way_i,
  output logic [icache_pkg::TAG_WIDTH-1:0]      tag_o,
  output logic [icache_pkg::WORD_SEL_WIDTH-1:0] word_sel_o,
  output logic                                  alloc_o,
  output logic [NUM_WAYS-1:0]                   tag_req_o,
  output logic [NUM_WAYS-1:0]                   tag_we_o,
  output logic [icache_pkg::INDEX_WIDTH-1:0]    tag_addr_o,
  output icache_pkg::tag_entry_t                tag_wdata_o,
  output logic [NUM_WAYS-1:0]                   data_req_o,
  output logic [NUM_WAYS-1:0]                   data_we_o,
  output logic [icache_pkg::INDEX_WIDTH-1:0]    data_addr_o,
  output logic                                  miss_o,
  output logic                                  busy_o
);
  import icache_pkg::*;

  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    READ,
    MISS,
    RESP
  } state_e;

  state_e                 state_d, state_q;
  logic                   flush_d, flush_q;
  logic [INDEX_WIDTH-1:0] flush_cnt_d, flush_cnt_q;
  logic                   refill_sent_d, refill_sent_q;

  // request payload
  logic [ADDR_WIDTH-1:0]  addr_q;
  logic [WAY_WIDTH-1:0]   repl_q;
  fetch_rsp_t             rsp_q;
  logic [FETCH_WIDTH-1:0] rsp_word;

  logic [INDEX_WIDTH-1:0] index_q;
  logic [INDEX_WIDTH-1:0] req_index;
  logic                   addr_nc;
  logic                   lookup_en, fill_en, flush_en, flush_done;
  logic                   inv_en, inv_hit, ack_en;
  logic                   rsp_load, repl_load;
  logic [NUM_WAYS-1:0]    inv_mask, repl_oh;

  ////////////////////
  // address split
  ////////////////////

  assign index_q    = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
  assign req_index  = req_i.paddr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag_o      = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign word_sel_o = addr_q[OFFSET_WIDTH-1:2];
  assign addr_nc    = addr_q[NC_BIT];

  // return port decode, flush walk overrides any invalidation
  assign inv_en  = rtrn_valid_i && (rtrn_i.rtype == RTRN_INV) && (state_q != FLUSH);
  assign ack_en  = rtrn_valid_i && (rtrn_i.rtype == RTRN_ACK) && (state_q == MISS)
                   && refill_sent_q;
  // invalidation racing the lookup of the same set
  assign inv_hit = inv_en && (rtrn_i.inv_idx == index_q);

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way_mask
    assign inv_mask[w] = rtrn_i.inv_all || (rtrn_i.inv_way == WAY_WIDTH'(w));
    assign repl_oh[w]  = (repl_q == WAY_WIDTH'(w));
  end

  assign flush_done = (flush_cnt_q == INDEX_WIDTH'(NUM_SETS - 1));
  assign lookup_en  = req_valid_i && req_ready_o;

  ////////////////////
  // main fsm
  ////////////////////

  always_comb begin
    state_d        = state_q;
    flush_d        = flush_q | flush_i;
    refill_sent_d  = refill_sent_q;
    flush_en       = 1'b0;
    req_ready_o    = 1'b0;
    refill_valid_o = 1'b0;
    miss_o         = 1'b0;
    fill_en        = 1'b0;
    rsp_load       = 1'b0;
    repl_load      = 1'b0;

    case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      // no lookup while an invalidation owns the tag array
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else if (!inv_en) begin
          req_ready_o = 1'b1;
          if (req_valid_i) begin
            state_d = READ;
          end
        end
      end
      // arrays were read on acceptance, compare now
      READ: begin
        if (hit_i && !addr_nc && !inv_hit) begin
          rsp_load = 1'b1;
          state_d  = RESP;
        end else begin
          repl_load     = 1'b1;
          refill_sent_d = 1'b0;
          state_d       = MISS;
        end
      end
      // send one refill, then wait for the line
      MISS: begin
        if (!refill_sent_q) begin
          refill_valid_o = 1'b1;
          if (refill_ready_i) begin
            refill_sent_d = 1'b1;
            miss_o        = !addr_nc;
          end
        end else if (ack_en) begin
          rsp_load      = 1'b1;
          // nc lines are passed through, never stored
          fill_en       = !addr_nc;
          refill_sent_d = 1'b0;
          state_d       = RESP;
        end
      end
      // hold the response until it is taken
      RESP: begin
        if (rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  assign flush_cnt_d = flush_en ? (flush_done ? '0 : flush_cnt_q + 1'b1) : flush_cnt_q;
  assign alloc_o     = fill_en;

  ////////////////////
  // array arbitration
  ////////////////////

  // priority is flush, invalidation, fill, lookup
  always_comb begin
    tag_req_o         = '0;
    tag_we_o          = '0;
    tag_addr_o        = req_index;
    tag_wdata_o.valid = 1'b0;
    tag_wdata_o.tag   = tag_o;
    data_req_o        = '0;
    data_we_o         = '0;
    data_addr_o       = req_index;
    if (flush_en) begin
      tag_req_o  = '1;
      tag_we_o   = '1;
      tag_addr_o = flush_cnt_q;
    end else if (inv_en) begin
      tag_req_o  = inv_mask;
      tag_we_o   = inv_mask;
      tag_addr_o = rtrn_i.inv_idx;
    end else if (fill_en) begin
      tag_req_o         = repl_oh;
      tag_we_o          = repl_oh;
      tag_addr_o        = index_q;
      tag_wdata_o.valid = 1'b1;
      data_req_o        = repl_oh;
      data_we_o         = repl_oh;
      data_addr_o       = index_q;
    end else if (lookup_en) begin
      // read every way of the set
      tag_req_o  = '1;
      data_req_o = '1;
    end
  end

  ////////////////////
  // registers
  ////////////////////

  // response word comes from the cache on a hit, else from the refill line
  assign rsp_word = (state_q == READ) ? hit_word_i
                                      : rtrn_i.data[word_sel_o*FETCH_WIDTH +: FETCH_WIDTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= FLUSH;
      flush_q       <= 1'b0;
      flush_cnt_q   <= '0;
      refill_sent_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      flush_q       <= flush_d;
      flush_cnt_q   <= flush_cnt_d;
      refill_sent_q <= refill_sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_en) begin
      addr_q <= req_i.paddr;
    end
    if (repl_load) begin
      repl_q <= repl_way_i;
    end
    if (rsp_load) begin
      rsp_q.paddr <= addr_q;
      rsp_q.data  <= rsp_word;
    end
  end

  assign rsp_valid_o = (state_q == RESP);
  assign rsp_o       = rsp_q;
  // refill is always a whole line
  assign refill_o.paddr = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign refill_o.nc    = addr_nc;
  assign refill_o.way   = repl_q;
  assign busy_o         = (state_q != IDLE);

endmodule

`default_nettype wire

// File: rtl/icache_way_select.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way_select #(
  parameter int unsigned NUM_WAYS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  icache_pkg::tag_entry_t [NUM_WAYS-1:0] tag_rdata_i,
  input  icache_pkg::line_t [NUM_WAYS-1:0]      line_rdata_i,
  input  logic [icache_pkg::TAG_WIDTH-1:0]      tag_i,
  input  logic [icache_pkg::WORD_SEL_WIDTH-1:0] word_sel_i,
  input  logic                                  alloc_i,
  output logic                                  hit_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0]    hit_word_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]      repl_way_o
);
  import icache_pkg::*;

  localparam int unsigned WAY_IDX_WIDTH = $clog2(NUM_WAYS);

  logic [NUM_WAYS-1:0]  way_valid;
  logic [NUM_WAYS-1:0]  way_hit;
  logic                 all_valid;
  logic [WAY_WIDTH-1:0] inv_way;
  logic [WAY_WIDTH-1:0] rnd_way;
  logic [7:0]           lfsr_q;
  logic                 lfsr_fb;

  ////////////////////
  // tag compare
  ////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign way_valid[w] = tag_rdata_i[w].valid;
    // only a valid entry can hit
    assign way_hit[w]   = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == tag_i);
  end

  assign hit_o = |way_hit;

  // word of the hit way, lowest way wins if two ever match
  always_comb begin
    hit_word_o = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_word_o = line_rdata_i[w][word_sel_i*FETCH_WIDTH +: FETCH_WIDTH];
      end
    end
  end

  ////////////////////
  // replacement
  ////////////////////

  assign all_valid = &way_valid;

  // lowest-numbered invalid way
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!way_valid[w]) begin
        inv_way = WAY_WIDTH'(w);
      end
    end
  end

  // 8-bit fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // only moves when a full set takes a new line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hff;
    end else if (alloc_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  // low lfsr bits index the way, upper way bits stay zero
  assign rnd_way = WAY_WIDTH'(lfsr_q[WAY_IDX_WIDTH-1:0]);

  assign repl_way_o = all_valid ? rnd_way : inv_way;

endmodule

`default_nettype wire

// File: rtl/icache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
  parameter int unsigned NUM_ENTRIES = 16,
  parameter type         entry_t     = logic [31:0]
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] addr_i,
  input  entry_t                         wdata_i,
  output entry_t                         rdata_o
);

  // one entry per set
  entry_t mem_q [NUM_ENTRIES];
  entry_t rdata_q;

  // write port, single access per cycle
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read data is registered and held until the next read
  // writes leave it alone so a pending lookup keeps its view of the set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // physical address and fetch word
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned FETCH_WIDTH    = 32;
  // one line holds four fetch words
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned OFFSET_WIDTH   = 4;
  // word index inside a line
  localparam int unsigned WORD_SEL_WIDTH = OFFSET_WIDTH - 2;
  localparam int unsigned NUM_SETS       = 16;
  localparam int unsigned INDEX_WIDTH    = 4;
  localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  // top address bit selects the non-cacheable region
  localparam int unsigned NC_BIT         = 31;
  // way fields cover up to 8 ways
  localparam int unsigned WAY_WIDTH      = 3;

  ////////////////////
  // port payloads
  ////////////////////

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]  paddr;
    logic [FETCH_WIDTH-1:0] data;
  } fetch_rsp_t;

  // line-aligned refill, way is the victim picked for the fill
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  nc;
    logic [WAY_WIDTH-1:0]  way;
  } refill_req_t;

  typedef enum logic {
    RTRN_ACK = 1'b0,
    RTRN_INV = 1'b1
  } rtrn_type_e;

  // memory return, either a whole refill line or an invalidation
  typedef struct packed {
    rtrn_type_e             rtype;
    logic [LINE_WIDTH-1:0]  data;
    logic [INDEX_WIDTH-1:0] inv_idx;
    logic [WAY_WIDTH-1:0]   inv_way;
    logic                   inv_all;
  } mem_rtrn_t;

  // tag array entry
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  typedef logic [LINE_WIDTH-1:0] line_t;

endpackage

`default_nettype wire
